//--- bpu_defs.svh
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// datapath
`define BPU_XLEN        32
`define BPU_HIST_W      16

// direction predictor geometry
`define BPU_BIM_IDX_W   9       // pc[9:1]
`define BPU_TAB_IDX_W   8
`define BPU_TAG_W       10
`define BPU_PTAG_W      6       // upper tag bits compared on lookup
`define BPU_NUM_BANKS   2

// target buffer, pc[9:2] index and pc[31:10] tag
`define BPU_BTB_IDX_W   8
`define BPU_BTB_TAG_W   22

// return stack
`define BPU_RAS_DEPTH   32
`define BPU_RAS_PTR_W   5

// rv32 opcodes and link registers
`define BPU_OP_BRANCH   7'b1100011
`define BPU_OP_JAL      7'b1101111
`define BPU_OP_JALR     7'b1100111
`define BPU_REG_RA      5'd1
`define BPU_REG_T0      5'd5

`endif

//--- bpu_pkg.sv
`include "bpu_defs.svh"

package bpu_pkg;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one fetch word, viewed per format
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
        i_fmt_t i;
    } inst_u;

    typedef logic [1:0] ctr_t;  // msb is the direction

    // jalr through ra or t0
    function automatic logic is_return(input inst_u inst);
        return (inst.i.opcode == `BPU_OP_JALR) &&
               ((inst.i.rs1 == `BPU_REG_RA) || (inst.i.rs1 == `BPU_REG_T0));
    endfunction

endpackage

//--- tage_hash.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module tage_hash (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic [`BPU_XLEN-1:0]                         if_pc_i,
    input  logic [`BPU_XLEN-1:0]                         ex_pc_i,
    input  logic [`BPU_HIST_W-1:0]                       ex_history_i,
    input  logic                                         ex_branch_valid_i,
    input  logic                                         ex_branch_taken_i,
    output logic [`BPU_NUM_BANKS-1:0][`BPU_TAB_IDX_W-1:0] pred_idx_o,
    output logic [`BPU_NUM_BANKS-1:0][`BPU_TAG_W-1:0]     pred_tag_o,
    output logic [`BPU_NUM_BANKS-1:0][`BPU_TAB_IDX_W-1:0] upd_idx_o,
    output logic [`BPU_NUM_BANKS-1:0][`BPU_TAG_W-1:0]     upd_tag_o,
    output logic [`BPU_HIST_W-1:0]                       history_o
);

    logic [`BPU_HIST_W-1:0] ghr_q;

    // bank 0 folds the low history bits into the index, bank 1 the high ones
    function automatic logic [`BPU_TAB_IDX_W-1:0] hash_idx(
        input int bank, input logic [`BPU_XLEN-1:0] pc, input logic [`BPU_HIST_W-1:0] hist);
        if (bank == 0)
            return pc[`BPU_TAB_IDX_W-1:0] ^ hist[`BPU_TAB_IDX_W-1:0];
        return pc[`BPU_TAB_IDX_W-1:0] ^ hist[`BPU_HIST_W-1 -: `BPU_TAB_IDX_W];
    endfunction

    function automatic logic [`BPU_TAG_W-1:0] hash_tag(
        input int bank, input logic [`BPU_XLEN-1:0] pc, input logic [`BPU_HIST_W-1:0] hist);
        logic [`BPU_TAG_W-1:0] pc_bits;
        pc_bits = pc[`BPU_TAB_IDX_W +: `BPU_TAG_W];    // pc[17:8]
        if (bank == 0)
            return pc_bits ^ hist[`BPU_HIST_W-1 -: `BPU_TAG_W];
        return pc_bits ^ {{(`BPU_TAG_W-8){1'b0}}, hist[7:0]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ghr_q <= '0;
        else if (ex_branch_valid_i)
            ghr_q <= {ghr_q[`BPU_HIST_W-2:0], ex_branch_taken_i};
    end

    assign history_o = ghr_q;

    // lookup uses the live history, training the history the branch was fetched with
    for (genvar k = 0; k < `BPU_NUM_BANKS; k++) begin : g_hash
        assign pred_idx_o[k] = hash_idx(k, if_pc_i, ghr_q);
        assign pred_tag_o[k] = hash_tag(k, if_pc_i, ghr_q);
        assign upd_idx_o[k]  = hash_idx(k, ex_pc_i, ex_history_i);
        assign upd_tag_o[k]  = hash_tag(k, ex_pc_i, ex_history_i);
    end

endmodule

//--- tage_bank.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module tage_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`BPU_TAB_IDX_W-1:0] pred_idx_i,
    input  logic [`BPU_TAG_W-1:0]     pred_tag_i,
    input  logic [`BPU_TAB_IDX_W-1:0] upd_idx_i,
    input  logic [`BPU_TAG_W-1:0]     upd_tag_i,
    input  logic                      upd_taken_i,
    input  logic                      train_i,
    input  logic                      alloc_i,
    output logic                      pred_hit_o,
    output bpu_pkg::ctr_t             pred_ctr_o,
    output logic                      upd_hit_o,
    output bpu_pkg::ctr_t             upd_ctr_o
);
    import bpu_pkg::*;

    localparam int Entries = 1 << `BPU_TAB_IDX_W;

    logic [`BPU_TAG_W-1:0] tag_q [Entries];
    ctr_t                  ctr_q [Entries];
    ctr_t                  ctr_next;
    logic                  upd_correct;

    // partial tag compare, upper bits only
    function automatic logic tag_match(input logic [`BPU_TAG_W-1:0] a,
                                       input logic [`BPU_TAG_W-1:0] b);
        return a[`BPU_TAG_W-1 -: `BPU_PTAG_W] == b[`BPU_TAG_W-1 -: `BPU_PTAG_W];
    endfunction

    assign pred_hit_o = tag_match(tag_q[pred_idx_i], pred_tag_i);
    assign pred_ctr_o = ctr_q[pred_idx_i];
    assign upd_hit_o  = tag_match(tag_q[upd_idx_i], upd_tag_i);
    assign upd_ctr_o  = ctr_q[upd_idx_i];

    assign upd_correct = upd_ctr_o[1] == upd_taken_i;

    always_comb begin
        ctr_next = upd_ctr_o;
        if (!upd_correct)
            ctr_next = upd_taken_i ? 2'b11 : 2'b00;    // jump to strong on a miss
        else if (upd_taken_i && upd_ctr_o != 2'b11)
            ctr_next = upd_ctr_o + 2'd1;
        else if (!upd_taken_i && upd_ctr_o != 2'b00)
            ctr_next = upd_ctr_o - 2'd1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < Entries; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= 2'b01;     // weak not taken
            end
        end else if (alloc_i) begin
            tag_q[upd_idx_i] <= upd_tag_i;
            ctr_q[upd_idx_i] <= upd_taken_i ? 2'b10 : 2'b01;
        end else if (train_i) begin
            ctr_q[upd_idx_i] <= ctr_next;
        end
    end

    // provider never trains and allocates the same bank at once
    a_train_alloc_excl: assert property (@(posedge clk) disable iff (rst)
        !(train_i && alloc_i));

endmodule

//--- tage_provider.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module tage_provider (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [`BPU_XLEN-1:0]                 if_pc_i,
    input  logic [`BPU_XLEN-1:0]                 ex_pc_i,
    input  logic                                 ex_branch_valid_i,
    input  logic                                 ex_branch_taken_i,
    input  logic [`BPU_NUM_BANKS-1:0]            pred_hit_i,
    input  bpu_pkg::ctr_t [`BPU_NUM_BANKS-1:0]   pred_ctr_i,
    input  logic [`BPU_NUM_BANKS-1:0]            upd_hit_i,
    output logic                                 pred_taken_o,
    output logic [`BPU_NUM_BANKS-1:0]            train_o,
    output logic [`BPU_NUM_BANKS-1:0]            alloc_o
);
    import bpu_pkg::*;

    localparam int BimEntries = 1 << `BPU_BIM_IDX_W;

    ctr_t                     bim_q [BimEntries];
    logic [`BPU_BIM_IDX_W-1:0] pred_bim_idx;
    logic [`BPU_BIM_IDX_W-1:0] upd_bim_idx;
    ctr_t                     upd_bim_ctr;
    logic                     bim_wrong;

    assign pred_bim_idx = if_pc_i[`BPU_BIM_IDX_W:1];
    assign upd_bim_idx  = ex_pc_i[`BPU_BIM_IDX_W:1];
    assign upd_bim_ctr  = bim_q[upd_bim_idx];

    // highest hitting bank wins, bimodal is the fallback
    always_comb begin
        pred_taken_o = bim_q[pred_bim_idx][1];
        for (int k = 0; k < `BPU_NUM_BANKS; k++) begin
            if (pred_hit_i[k])
                pred_taken_o = pred_ctr_i[k][1];
        end
    end

    // base provided at update time when no bank tag matched
    assign bim_wrong = ~|upd_hit_i && (upd_bim_ctr[1] != ex_branch_taken_i);

    always_comb begin
        train_o = '0;
        alloc_o = '0;
        for (int k = 0; k < `BPU_NUM_BANKS; k++) begin
            if (upd_hit_i[k]) begin
                train_o    = '0;
                train_o[k] = ex_branch_valid_i;
            end else if (bim_wrong) begin
                alloc_o    = '0;
                alloc_o[k] = ex_branch_valid_i;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BimEntries; i++)
                bim_q[i] <= 2'b01;
        end else if (ex_branch_valid_i) begin
            if (ex_branch_taken_i && upd_bim_ctr != 2'b11)
                bim_q[upd_bim_idx] <= upd_bim_ctr + 2'd1;
            else if (!ex_branch_taken_i && upd_bim_ctr != 2'b00)
                bim_q[upd_bim_idx] <= upd_bim_ctr - 2'd1;
        end
    end

    a_train_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(train_o));
    a_alloc_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(alloc_o));

endmodule

//--- btb.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module btb (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`BPU_XLEN-1:0] if_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_target_i,
    input  logic                 ex_branch_valid_i,
    input  logic                 ex_branch_taken_i,
    output logic                 hit_o,
    output logic [`BPU_XLEN-1:0] target_o
);

    localparam int Entries = 1 << `BPU_BTB_IDX_W;

    logic [`BPU_BTB_TAG_W-1:0] tag_q    [Entries];
    logic [`BPU_XLEN-1:0]      target_q [Entries];
    logic [Entries-1:0]        valid_q;

    logic [`BPU_BTB_IDX_W-1:0] rd_idx;
    logic [`BPU_BTB_IDX_W-1:0] wr_idx;
    logic                      wr_en;

    assign rd_idx = if_pc_i[`BPU_BTB_IDX_W+1:2];
    assign wr_idx = ex_pc_i[`BPU_BTB_IDX_W+1:2];
    assign wr_en  = ex_branch_valid_i && ex_branch_taken_i;   // fill on every taken

    assign hit_o    = valid_q[rd_idx] &&
                      (tag_q[rd_idx] == if_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_W]);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= '0;
        else if (wr_en)
            valid_q[wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= ex_pc_i[`BPU_XLEN-1 -: `BPU_BTB_TAG_W];
            target_q[wr_idx] <= ex_target_i;
        end
    end

endmodule

//--- ras.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module ras (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push_valid_i,
    input  logic [`BPU_XLEN-1:0] push_data_i,
    input  logic                 ex_branch_valid_i,
    input  logic                 ex_branch_taken_i,
    input  bpu_pkg::inst_u       ex_inst_i,
    input  logic                 ex_stall_i,
    output logic                 top_valid_o,
    output logic [`BPU_XLEN-1:0] top_o
);
    import bpu_pkg::*;

    logic [`BPU_XLEN-1:0]    stack_q [`BPU_RAS_DEPTH];
    logic [`BPU_RAS_PTR_W:0] sp_q;      // entry count, one bit wider than the index
    logic [`BPU_RAS_PTR_W:0] sp_mid;
    logic [`BPU_RAS_PTR_W-1:0] top_idx;
    logic                    pop;
    logic                    push;

    assign top_valid_o = sp_q != '0;
    assign top_idx     = sp_q[`BPU_RAS_PTR_W-1:0] - 1'b1;
    assign top_o       = stack_q[top_idx];

    assign pop = ex_branch_valid_i && ex_branch_taken_i && !ex_stall_i &&
                 is_return(ex_inst_i) && top_valid_o;

    // pop first, then push into the freed slot
    assign sp_mid = sp_q - {{`BPU_RAS_PTR_W{1'b0}}, pop};
    assign push   = push_valid_i && !ex_stall_i && (sp_mid != `BPU_RAS_DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp_q <= '0;
        else
            sp_q <= sp_mid + {{`BPU_RAS_PTR_W{1'b0}}, push};
    end

    always_ff @(posedge clk) begin
        if (push)
            stack_q[sp_mid[`BPU_RAS_PTR_W-1:0]] <= push_data_i;
    end

    a_sp_bound: assert property (@(posedge clk) disable iff (rst)
        sp_q <= `BPU_RAS_DEPTH);

endmodule

//--- tage_bpu.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module tage_bpu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`BPU_XLEN-1:0]   if_pc_i,
    input  logic [`BPU_XLEN-1:0]   if_inst_i,
    input  logic                   id_ras_push_valid_i,
    input  logic [`BPU_XLEN-1:0]   id_ras_push_data_i,
    input  logic                   ex_branch_valid_i,
    input  logic                   ex_branch_taken_i,
    input  logic [`BPU_XLEN-1:0]   ex_pc_i,
    input  logic [`BPU_HIST_W-1:0] ex_history_i,
    input  logic [`BPU_XLEN-1:0]   ex_target_i,
    input  logic [`BPU_XLEN-1:0]   ex_inst_i,
    input  logic                   ex_stall_i,
    output logic                   branch_or_not_o,
    output logic [`BPU_XLEN-1:0]   pdt_pc_o,
    output logic                   pdt_res_o,
    output logic [`BPU_HIST_W-1:0] history_o
);
    import bpu_pkg::*;

    localparam int NB = `BPU_NUM_BANKS;

    logic [NB-1:0][`BPU_TAB_IDX_W-1:0] pred_idx, upd_idx;
    logic [NB-1:0][`BPU_TAG_W-1:0]     pred_tag, upd_tag;
    logic [NB-1:0]                     pred_hit, upd_hit, train, alloc;
    ctr_t [NB-1:0]                     pred_ctr;
    logic                              pred_taken;
    logic                              btb_hit, ras_valid;
    logic [`BPU_XLEN-1:0]              btb_target, ras_top;

    inst_u                inst;
    logic                 is_br, is_jal, is_jalr, is_ret;
    logic [`BPU_XLEN-1:0] b_imm, j_imm, pc_plus4;

    tage_hash i_hash (
        .clk, .rst, .if_pc_i, .ex_pc_i, .ex_history_i, .ex_branch_valid_i,
        .ex_branch_taken_i, .pred_idx_o(pred_idx), .pred_tag_o(pred_tag),
        .upd_idx_o(upd_idx), .upd_tag_o(upd_tag), .history_o
    );

    for (genvar k = 0; k < NB; k++) begin : g_bank
        tage_bank i_bank (
            .clk, .rst,
            .pred_idx_i(pred_idx[k]), .pred_tag_i(pred_tag[k]),
            .upd_idx_i(upd_idx[k]), .upd_tag_i(upd_tag[k]),
            .upd_taken_i(ex_branch_taken_i), .train_i(train[k]), .alloc_i(alloc[k]),
            .pred_hit_o(pred_hit[k]), .pred_ctr_o(pred_ctr[k]),
            .upd_hit_o(upd_hit[k]), .upd_ctr_o()    // counter check stays inside the bank
        );
    end

    tage_provider i_provider (
        .clk, .rst, .if_pc_i, .ex_pc_i, .ex_branch_valid_i, .ex_branch_taken_i,
        .pred_hit_i(pred_hit), .pred_ctr_i(pred_ctr), .upd_hit_i(upd_hit),
        .pred_taken_o(pred_taken), .train_o(train), .alloc_o(alloc)
    );

    btb i_btb (
        .clk, .rst, .if_pc_i, .ex_pc_i, .ex_target_i, .ex_branch_valid_i,
        .ex_branch_taken_i, .hit_o(btb_hit), .target_o(btb_target)
    );

    ras i_ras (
        .clk, .rst, .push_valid_i(id_ras_push_valid_i), .push_data_i(id_ras_push_data_i),
        .ex_branch_valid_i, .ex_branch_taken_i, .ex_inst_i(ex_inst_i), .ex_stall_i,
        .top_valid_o(ras_valid), .top_o(ras_top)
    );

    assign inst    = if_inst_i;
    assign is_br   = inst.b.opcode == `BPU_OP_BRANCH;
    assign is_jal  = inst.j.opcode == `BPU_OP_JAL;
    assign is_jalr = inst.i.opcode == `BPU_OP_JALR;
    assign is_ret  = is_return(inst) && inst.i.rd == 5'd0 && inst.i.imm == 12'd0;   // plain ret

    assign b_imm = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign j_imm = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};
    assign pc_plus4 = if_pc_i + 32'd4;

    always_comb begin
        branch_or_not_o = is_br || is_jal || is_jalr;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;
        if (is_ret) begin
            pdt_res_o = ras_valid;
            if (ras_valid)
                pdt_pc_o = ras_top;
        end else if (is_jal) begin
            pdt_res_o = 1'b1;
            pdt_pc_o  = btb_hit ? btb_target : if_pc_i + j_imm;
        end else if (is_br || is_jalr) begin
            pdt_res_o = pred_taken;
            if (pred_taken && btb_hit)
                pdt_pc_o = btb_target;
            else if (pred_taken && is_br)
                pdt_pc_o = if_pc_i + b_imm;  // jalr without a btb entry falls through
        end
    end

endmodule

//--- tb_tage_bpu.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module tb_tage_bpu;
    import bpu_pkg::*;

    localparam int Period  = 8;
    localparam int NB      = `BPU_NUM_BANKS;
    localparam int BimSize = 1 << `BPU_BIM_IDX_W;
    localparam int TabSize = 1 << `BPU_TAB_IDX_W;
    localparam int BtbSize = 1 << `BPU_BTB_IDX_W;
    localparam int NPlain  = 200;
    localparam int NJal    = 20;
    localparam int NPush   = 12;
    localparam int NHist   = 100;
    localparam int NMix    = 2000;
    // jal rounds take three cycles, stalled pops stretch the stack test
    localparam int TotalCycles = NPlain + 3 * NJal + 8 + 4 * NPush + NHist + NMix;
    localparam logic [31:0] RetInst = 32'h0000_8067;    // jalr x0, 0(ra)

    logic                   clk, rst;
    logic [`BPU_XLEN-1:0]   if_pc_i, if_inst_i, id_ras_push_data_i;
    logic [`BPU_XLEN-1:0]   ex_pc_i, ex_target_i, ex_inst_i, pdt_pc_o;
    logic [`BPU_HIST_W-1:0] ex_history_i, history_o;
    logic                   id_ras_push_valid_i, ex_branch_valid_i, ex_branch_taken_i;
    logic                   ex_stall_i, branch_or_not_o, pdt_res_o;

    // reference state
    logic [`BPU_HIST_W-1:0]    m_hist;
    ctr_t                      m_bim [BimSize];
    logic [`BPU_TAG_W-1:0]     m_tag [NB][TabSize];
    ctr_t                      m_ctr [NB][TabSize];
    logic                      m_btb_v [BtbSize];
    logic [`BPU_BTB_TAG_W-1:0] m_btb_tag [BtbSize];
    logic [`BPU_XLEN-1:0]      m_btb_tgt [BtbSize];
    logic [`BPU_XLEN-1:0]      m_ras [`BPU_RAS_DEPTH];
    int                        m_sp;

    string cur_test;
    int    errors, checks, test_errs, tests_passed, tests_failed;

    tage_bpu i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        #((TotalCycles + 500) * Period);
        $display("watchdog expired, tests did not finish in %0d cycles", TotalCycles + 500);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [7:0] tab_index(int k, logic [31:0] pc, logic [15:0] h);
        return pc[7:0] ^ ((k == 0) ? h[7:0] : h[15:8]);
    endfunction

    function automatic logic [9:0] tab_tag(int k, logic [31:0] pc, logic [15:0] h);
        return pc[17:8] ^ ((k == 0) ? h[15:6] : {2'b00, h[7:0]});
    endfunction

    function automatic logic tag_hit(int k, logic [31:0] pc, logic [15:0] h);
        logic [9:0] t;
        t = tab_tag(k, pc, h);
        return m_tag[k][tab_index(k, pc, h)][9:4] == t[9:4];   // six upper bits only
    endfunction

    function automatic ctr_t sat_step(ctr_t c, logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'd1;
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic logic model_dir(logic [31:0] pc);
        logic d;
        d = m_bim[pc[9:1]][1];
        for (int k = 0; k < NB; k++) begin
            if (tag_hit(k, pc, m_hist))
                d = m_ctr[k][tab_index(k, pc, m_hist)][1];
        end
        return d;
    endfunction

    function automatic logic [31:0] rand_inst(int kind);
        logic [31:0] w;
        w = $urandom;
        case (kind)
            0: if (w[6:0] inside {`BPU_OP_BRANCH, `BPU_OP_JAL, `BPU_OP_JALR}) w[6:0] = 7'h13;
            1: w[6:0] = `BPU_OP_BRANCH;
            2: w[6:0] = `BPU_OP_JAL;
            3: w = $urandom % 2 ? RetInst : 32'h0002_8067;   // ret via ra or t0
            default: w[6:0] = `BPU_OP_JALR;
        endcase
        return w;
    endfunction

    // small pool so tables alias
    function automatic logic [31:0] pool_pc();
        return (($urandom % 8) << 12) | (($urandom % 16) << 2);
    endfunction

    task automatic model_predict(input logic [31:0] pc, input inst_u w, output logic br,
                                 output logic tk, output logic [31:0] tgt);
        logic [7:0]  bi;
        logic        hit, ret;
        logic [31:0] bimm, jimm;
        bi   = pc[9:2];
        hit  = m_btb_v[bi] && m_btb_tag[bi] == pc[31:10];
        bimm = {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
        jimm = {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
        ret  = w.i.opcode == `BPU_OP_JALR && (w.i.rs1 == 5'd1 || w.i.rs1 == 5'd5) &&
               w.i.rd == 5'd0 && w.i.imm == 12'd0;
        br   = w.i.opcode inside {`BPU_OP_BRANCH, `BPU_OP_JAL, `BPU_OP_JALR};
        tk   = 1'b0;
        tgt  = pc + 32'd4;
        if (ret) begin
            tk = m_sp > 0;
            if (tk)
                tgt = m_ras[m_sp - 1];
        end else if (w.i.opcode == `BPU_OP_JAL) begin
            tk  = 1'b1;
            tgt = hit ? m_btb_tgt[bi] : pc + jimm;
        end else if (br) begin
            tk = model_dir(pc);
            if (tk && hit)
                tgt = m_btb_tgt[bi];
            else if (tk && w.i.opcode == `BPU_OP_BRANCH)
                tgt = pc + bimm;
        end
    endtask

    // state change at the edge, all decisions from the old state
    task automatic model_update();
        inst_u w;
        logic  pop, push, tk;
        int    sp_mid, prov;
        ctr_t  c;
        logic [7:0] idx;
        w   = ex_inst_i;
        tk  = ex_branch_taken_i;
        pop = ex_branch_valid_i && tk && !ex_stall_i && w.i.opcode == `BPU_OP_JALR &&
              (w.i.rs1 == 5'd1 || w.i.rs1 == 5'd5) && m_sp > 0;
        sp_mid = m_sp - int'(pop);
        push   = id_ras_push_valid_i && !ex_stall_i && sp_mid < `BPU_RAS_DEPTH;
        if (push)
            m_ras[sp_mid] = id_ras_push_data_i;
        m_sp = sp_mid + int'(push);
        if (ex_branch_valid_i) begin
            prov = -1;
            for (int k = 0; k < NB; k++) begin
                if (tag_hit(k, ex_pc_i, ex_history_i))
                    prov = k;
            end
            if (prov >= 0) begin
                idx = tab_index(prov, ex_pc_i, ex_history_i);
                c   = m_ctr[prov][idx];
                m_ctr[prov][idx] = (c[1] == tk) ? sat_step(c, tk) : {tk, tk};
            end else if (m_bim[ex_pc_i[9:1]][1] != tk) begin
                idx = tab_index(NB - 1, ex_pc_i, ex_history_i);   // every bank missed
                m_tag[NB-1][idx] = tab_tag(NB - 1, ex_pc_i, ex_history_i);
                m_ctr[NB-1][idx] = tk ? 2'b10 : 2'b01;
            end
            m_bim[ex_pc_i[9:1]] = sat_step(m_bim[ex_pc_i[9:1]], tk);
            if (tk) begin
                m_btb_v[ex_pc_i[9:2]]   = 1'b1;
                m_btb_tag[ex_pc_i[9:2]] = ex_pc_i[31:10];
                m_btb_tgt[ex_pc_i[9:2]] = ex_target_i;
            end
            m_hist = {m_hist[14:0], tk};
        end
    endtask

    task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        errors++;
        test_errs++;
        $display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
    endtask

    task automatic check_outputs();
        logic        br, tk;
        logic [31:0] tgt;
        model_predict(if_pc_i, if_inst_i, br, tk, tgt);
        checks++;
        if (branch_or_not_o !== br)
            report_mismatch("branch_or_not", 32'(br), 32'(branch_or_not_o));
        if (pdt_res_o !== tk)
            report_mismatch("pdt_res", 32'(tk), 32'(pdt_res_o));
        if (pdt_pc_o !== tgt)
            report_mismatch("pdt_pc", tgt, pdt_pc_o);
        if (history_o !== m_hist)
            report_mismatch("history", 32'(m_hist), 32'(history_o));
    endtask

    // called 1 ns after an edge with inputs driven
    task automatic step();
        #(Period - 3);
        check_outputs();
        @(posedge clk);
        model_update();
        #1;
    endtask

    task automatic idle_inputs();
        id_ras_push_valid_i = 1'b0;
        id_ras_push_data_i  = '0;
        ex_branch_valid_i   = 1'b0;
        ex_branch_taken_i   = 1'b0;
        ex_pc_i             = '0;
        ex_history_i        = '0;
        ex_target_i         = '0;
        ex_inst_i           = 32'h0000_0013;
        ex_stall_i          = 1'b0;
    endtask

    task automatic apply_reset();
        rst  = 1'b1;
        m_hist = '0;
        m_sp   = 0;
        for (int i = 0; i < BimSize; i++)
            m_bim[i] = 2'b01;
        for (int k = 0; k < NB; k++) begin
            for (int i = 0; i < TabSize; i++) begin
                m_tag[k][i] = '0;
                m_ctr[k][i] = 2'b01;
            end
        end
        for (int i = 0; i < BtbSize; i++)
            m_btb_v[i] = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic random_update(int valid_pct);
        ex_branch_valid_i = ($urandom % 100) < valid_pct;
        ex_branch_taken_i = 1'($urandom);
        ex_pc_i           = pool_pc();
        ex_inst_i         = rand_inst($urandom % 5);
        ex_target_i       = $urandom & ~32'h3;
        ex_history_i      = ($urandom % 4 == 0) ? 16'($urandom) : m_hist;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %s finished, %0d errors", cur_test, test_errs);
        end else begin
            tests_failed++;
            $display("test %s failed, %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        logic [31:0] pc, w;
        void'($urandom(63));
        if_pc_i   = '0;
        if_inst_i = 32'h0000_0013;
        idle_inputs();
        apply_reset();

        cur_test = "plain";
        for (int i = 0; i < NPlain; i++) begin
            if_pc_i   = $urandom & ~32'h3;
            if_inst_i = rand_inst(0);
            step();
        end
        end_test();

        cur_test = "jal";
        for (int r = 0; r < NJal; r++) begin
            if_pc_i   = 32'h0004_0000 + r * 4;    // own btb slot, cold
            if_inst_i = rand_inst(2);
            step();
            ex_branch_valid_i = 1'b1;
            ex_branch_taken_i = 1'b1;
            ex_pc_i           = if_pc_i;
            ex_inst_i         = if_inst_i;
            ex_history_i      = m_hist;
            ex_target_i       = $urandom & ~32'h3;
            step();
            idle_inputs();
            step();
        end
        end_test();

        cur_test = "branch";
        apply_reset();
        pc        = 32'h0000_0100;
        w         = rand_inst(1);
        if_pc_i   = pc;
        if_inst_i = w;
        step();
        ex_branch_valid_i = 1'b1;
        ex_branch_taken_i = 1'b1;
        ex_pc_i           = pc;
        ex_inst_i         = w;
        ex_target_i = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        repeat (2) begin
            ex_history_i = m_hist;
            step();
        end
        idle_inputs();
        step();
        end_test();

        cur_test = "ras";
        if_inst_i = RetInst;
        for (int i = 0; i < NPush; i++) begin
            if_pc_i             = pool_pc();
            id_ras_push_valid_i = 1'b1;
            id_ras_push_data_i  = $urandom & ~32'h3;
            ex_stall_i          = ($urandom % 4) == 0;
            step();
        end
        id_ras_push_valid_i = 1'b0;
        while (m_sp > 0) begin
            random_update(100);
            ex_branch_taken_i = 1'b1;
            ex_inst_i         = RetInst;
            ex_stall_i        = ($urandom % 4) == 0;
            if_pc_i           = pool_pc();
            step();
        end
        idle_inputs();
        step();    // empty stack
        end_test();

        cur_test = "history";
        for (int i = 0; i < NHist; i++) begin
            random_update(75);
            if_pc_i   = pool_pc();
            if_inst_i = rand_inst(1);
            step();
        end
        end_test();

        cur_test = "mixed";
        for (int i = 0; i < NMix; i++) begin
            random_update(60);
            ex_stall_i          = ($urandom % 10) == 0;
            id_ras_push_valid_i = ($urandom % 5) == 0;
            id_ras_push_data_i  = $urandom & ~32'h3;
            if_pc_i             = pool_pc();
            if_inst_i           = rand_inst($urandom % 5);
            step();
        end
        end_test();

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- tage_bpu.f
+incdir+.
bpu_pkg.sv
tage_hash.sv
tage_bank.sv
tage_provider.sv
btb.sv
ras.sv
tage_bpu.sv
tb_tage_bpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tage_bpu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FLIST := tage_bpu.f
SRCS  := $(filter-out +%,$(shell cat $(FLIST))) bpu_defs.svh
BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
